//--- lvda.f
verilog/lvda_pkg.sv
verilog/input_filter.sv
verilog/interrupt_latch.sv
verilog/countdown_timer.sv
verilog/readout_buffer.sv
verilog/lvda_top.sv
tb/lvda_tb.sv

//--- Makefile
# Verilator simulation of the launch vehicle data adapter

VERILATOR ?= verilator
TOP       ?= lvda_tb
FILELIST  ?= lvda.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Simulation PASSED

.PHONY: sim clean

# pass only when the run prints the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(BUILD_DIR)

//--- tb/lvda_testdata.txt
// one command per line, hex words: op addr data din intr expect
// op 0 wait, 1 read, 2 write, 3 check intc, 4 check timer_done pulses, 5 read in range, f end
// discretes
0 000 0000000 000000 00 0000000
1 008 0000000 000000 00 0000000
0 000 0000000 a5c33c 00 0000000
1 008 0000000 a5c33c 00 0a5c33c
0 000 0000000 ffffff 00 0000000
1 008 0000000 ffffff 00 0ffffff
0 000 0000000 123456 00 0000000
1 008 0000000 123456 00 0123456
// interrupt latch and clear
3 000 0000000 123456 00 0000000
1 00c 0000000 123456 00 0000000
0 000 0000000 123456 05 0000000
3 000 0000000 123456 05 0000001
1 00c 0000000 123456 05 0000005
0 000 0000000 123456 45 0000000
1 00c 0000000 123456 45 0000045
2 00c 0000001 123456 45 0000000
1 00c 0000000 123456 45 0000044
3 000 0000000 123456 45 0000001
2 00c 0000044 123456 45 0000000
1 00c 0000000 123456 45 0000000
3 000 0000000 123456 45 0000000
0 000 0000000 123456 00 0000000
1 00c 0000000 123456 00 0000000
0 000 0000000 123456 01 0000000
1 00c 0000000 123456 01 0000001
2 00c 0000002 123456 01 0000000
1 00c 0000000 123456 01 0000001
2 00c 0000001 123456 01 0000000
3 000 0000000 123456 01 0000000
// countdown timer, load 40 then wait past expiry
2 010 0000028 123456 01 0000000
5 010 0000000 123456 01 0000028
0 000 0000000 123456 01 0000000
0 000 0000000 123456 01 0000000
0 000 0000000 123456 01 0000000
0 000 0000000 123456 01 0000000
4 000 0000000 123456 01 0000001
1 010 0000000 123456 01 0000000
2 010 0000000 123456 01 0000000
0 000 0000000 123456 01 0000000
4 000 0000000 123456 01 0000000
1 010 0000000 123456 01 0000000
// unmapped reads and writes
1 000 0000000 123456 01 0000000
1 1ff 0000000 123456 01 0000000
1 014 0000000 123456 01 0000000
2 1ff 3ffffff 123456 01 0000000
2 008 3ffffff 123456 01 0000000
1 008 0000000 123456 01 0123456
f 000 0000000 000000 00 0000000

//--- tb/lvda_tb.sv
`timescale 1ns/1ps

module lvda_tb;

    localparam int RESET_CYCLES    = 10;
    localparam int HOLD_CYCLES     = 10;  // enough for the input filters to settle
    localparam int CYCLES_PER_LINE = 20;
    localparam int MAX_LINES       = 128;
    localparam int FIELDS          = 6;   // words per testdata line

    localparam logic [3:0] OP_WAIT   = 4'h0;
    localparam logic [3:0] OP_READ   = 4'h1;
    localparam logic [3:0] OP_WRITE  = 4'h2;
    localparam logic [3:0] OP_INTC   = 4'h3;
    localparam logic [3:0] OP_PULSES = 4'h4;
    localparam logic [3:0] OP_RANGE  = 4'h5;
    localparam logic [3:0] OP_END    = 4'hf;

    logic                 sim_clk;
    logic                 arst_n;
    lvda_pkg::din_word_t  din;
    lvda_pkg::intr_word_t intr;
    logic                 pio_strobe;
    logic                 pio_write;
    lvda_pkg::pio_addr_t  pio_addr;
    lvda_pkg::word_t      pio_data;
    lvda_pkg::word_t      brd;
    logic                 data_valid;
    logic                 intc;
    logic                 timer_done;

    logic [31:0] testdata [0:FIELDS*MAX_LINES-1];

    int line_count;
    int cycle_cnt       = 0;
    int cycle_limit     = RESET_CYCLES + MAX_LINES * CYCLES_PER_LINE;
    int valid_seen      = 0;  // cycles with data_valid high
    int pulse_seen      = 0;  // cycles with timer_done high
    int pulse_base      = 0;  // pulse_seen at the last timer load
    int value_errors    = 0;
    int protocol_errors = 0;

    lvda_top dut (
        .sim_clk   (sim_clk),
        .arst_n    (arst_n),
        .din       (din),
        .intr      (intr),
        .pio_strobe(pio_strobe),
        .pio_write (pio_write),
        .pio_addr  (pio_addr),
        .pio_data  (pio_data),
        .brd       (brd),
        .data_valid(data_valid),
        .intc      (intc),
        .timer_done(timer_done)
    );

    initial begin
        sim_clk = 1'b0;
        forever #5 sim_clk = ~sim_clk;
    end

    // sampled before the edge's updates land
    always @(posedge sim_clk) begin
        if (data_valid === 1'b1) begin
            valid_seen++;
        end
        if (timer_done === 1'b1) begin
            pulse_seen++;
        end
    end

    always @(posedge sim_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles, the command sequence did not finish", cycle_cnt);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input lvda_pkg::word_t actual,
                               input lvda_pkg::word_t expected);
        assert (actual === expected) else begin
            value_errors++;
            $display("error at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        assert (actual === expected) else begin
            value_errors++;
            $display("error at %0t ns: %s = %b, expected %b", $time, name, actual, expected);
        end
    endtask

    // read right after a timer load must see a count in 1..limit
    task automatic check_range(input lvda_pkg::word_t actual, input lvda_pkg::word_t limit);
        assert (actual != '0 && actual <= limit) else begin
            value_errors++;
            $display("error at %0t ns: brd = %h, expected 1 to %h", $time, actual, limit);
        end
    endtask

    task automatic apply_line(input int idx);
        int              base;
        int              valid_base;
        logic [3:0]      op;
        logic            is_read;
        lvda_pkg::word_t expected;
        base       = idx * FIELDS;
        op         = testdata[base][3:0];
        expected   = testdata[base+5][25:0];
        is_read    = (op == OP_READ) || (op == OP_RANGE);
        valid_base = valid_seen;
        din        = testdata[base+3][23:0];
        intr       = testdata[base+4][6:0];
        if (is_read || op == OP_WRITE) begin
            pio_strobe = 1'b1;
            pio_write  = (op == OP_WRITE);
            pio_addr   = testdata[base+1][8:0];
            pio_data   = testdata[base+2][25:0];
            if (op == OP_WRITE && pio_addr == lvda_pkg::ADDR_TIMER) begin
                pulse_base = pulse_seen;
            end
        end
        @(negedge sim_clk);
        pio_strobe = 1'b0;
        pio_write  = 1'b0;
        if (op == OP_READ) begin
            check_bit("data_valid", data_valid, 1'b1);
            check_value("brd", brd, expected);
        end else if (op == OP_RANGE) begin
            check_bit("data_valid", data_valid, 1'b1);
            check_range(brd, expected);
        end
        repeat (HOLD_CYCLES - 1) @(negedge sim_clk);
        check_value("data_valid cycles", lvda_pkg::word_t'(valid_seen - valid_base),
                    is_read ? lvda_pkg::word_t'(1) : '0);
        case (op)
            OP_WAIT, OP_READ, OP_WRITE, OP_RANGE: begin
            end
            OP_INTC: begin
                check_bit("intc", intc, expected[0]);
            end
            OP_PULSES: begin
                check_value("timer_done pulses", lvda_pkg::word_t'(pulse_seen - pulse_base),
                            expected);
            end
            default: begin
                protocol_errors++;
                $display("testdata line %0d has an unknown operation %h", idx, op);
            end
        endcase
    endtask

    initial begin
        arst_n     = 1'b0;
        din        = '0;
        intr       = '0;
        pio_strobe = 1'b0;
        pio_write  = 1'b0;
        pio_addr   = '0;
        pio_data   = '0;

        $readmemh("tb/lvda_testdata.txt", testdata);
        line_count = 0;
        while (line_count < MAX_LINES && testdata[line_count*FIELDS][3:0] !== OP_END) begin
            line_count++;
        end
        if (line_count == MAX_LINES) begin
            protocol_errors++;
            $display("testdata has no end marker within %0d lines", MAX_LINES);
        end
        cycle_limit = line_count * CYCLES_PER_LINE + RESET_CYCLES;

        repeat (RESET_CYCLES) @(negedge sim_clk);
        arst_n = 1'b1;

        // reset state
        check_value("brd", brd, '0);
        check_bit("data_valid", data_valid, 1'b0);
        check_bit("intc", intc, 1'b0);
        check_bit("timer_done", timer_done, 1'b0);

        for (int i = 0; i < line_count; i++) begin
            apply_line(i);
        end

        $display("value errors: %0d, other errors: %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- verilog/lvda_top.sv
`timescale 1ns/1ps
`default_nettype none

module lvda_top (
    input  logic                 sim_clk,
    input  logic                 arst_n,
    input  lvda_pkg::din_word_t  din,
    input  lvda_pkg::intr_word_t intr,
    input  logic                 pio_strobe,
    input  logic                 pio_write,
    input  lvda_pkg::pio_addr_t  pio_addr,
    input  lvda_pkg::word_t      pio_data,
    output lvda_pkg::word_t      brd,
    output logic                 data_valid,
    output logic                 intc,
    output logic                 timer_done
);

    lvda_pkg::din_word_t  din_filt;
    lvda_pkg::intr_word_t intr_filt;
    lvda_pkg::intr_word_t pending;
    lvda_pkg::intr_word_t clear_mask;
    lvda_pkg::count_t     count;
    lvda_pkg::count_t     load_value;
    logic                 wr_cmd;
    logic                 clear;
    logic                 load;

    // write decode
    assign wr_cmd = pio_strobe && pio_write;
    assign clear  = wr_cmd && (pio_addr == lvda_pkg::ADDR_INTR);
    assign load   = wr_cmd && (pio_addr == lvda_pkg::ADDR_TIMER);

    assign clear_mask = pio_data[lvda_pkg::INTR_COUNT-1:0];
    assign load_value = pio_data[lvda_pkg::TIMER_WIDTH-1:0];

    input_filter #(
        .payload_t(lvda_pkg::din_word_t)
    ) din_filter (
        .sim_clk (sim_clk),
        .arst_n  (arst_n),
        .raw     (din),
        .filtered(din_filt)
    );

    input_filter #(
        .payload_t(lvda_pkg::intr_word_t)
    ) intr_filter (
        .sim_clk (sim_clk),
        .arst_n  (arst_n),
        .raw     (intr),
        .filtered(intr_filt)
    );

    interrupt_latch u_interrupt_latch (
        .sim_clk   (sim_clk),
        .arst_n    (arst_n),
        .intr      (intr_filt),
        .clear     (clear),
        .clear_mask(clear_mask),
        .pending   (pending),
        .intc      (intc)
    );

    countdown_timer u_countdown_timer (
        .sim_clk   (sim_clk),
        .arst_n    (arst_n),
        .load      (load),
        .load_value(load_value),
        .count     (count),
        .timer_done(timer_done)
    );

    readout_buffer u_readout_buffer (
        .sim_clk   (sim_clk),
        .arst_n    (arst_n),
        .pio_strobe(pio_strobe),
        .pio_write (pio_write),
        .pio_addr  (pio_addr),
        .discretes (din_filt),
        .pending   (pending),
        .count     (count),
        .brd       (brd),
        .data_valid(data_valid)
    );

endmodule
`default_nettype wire

//--- verilog/readout_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module readout_buffer (
    input  logic                 sim_clk,
    input  logic                 arst_n,
    input  logic                 pio_strobe,
    input  logic                 pio_write,
    input  lvda_pkg::pio_addr_t  pio_addr,
    input  lvda_pkg::din_word_t  discretes,
    input  lvda_pkg::intr_word_t pending,
    input  lvda_pkg::count_t     count,
    output lvda_pkg::word_t      brd,
    output logic                 data_valid
);

    logic            rd_cmd;
    lvda_pkg::word_t rd_word;

    assign rd_cmd = pio_strobe && !pio_write;

    // source select, zero extended to the buffer width
    always_comb begin
        case (pio_addr)
            lvda_pkg::ADDR_DISCRETE: begin
                rd_word = lvda_pkg::word_t'(discretes);
            end
            lvda_pkg::ADDR_INTR: begin
                rd_word = lvda_pkg::word_t'(pending);
            end
            lvda_pkg::ADDR_TIMER: begin
                rd_word = lvda_pkg::word_t'(count);  // value before this edge's decrement
            end
            default: begin
                rd_word = '0;  // unmapped reads still answer
            end
        endcase
    end

    // buffer holds until the next read
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            brd <= '0;
        end else if (rd_cmd) begin
            brd <= rd_word;
        end
    end

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            data_valid <= 1'b0;
        end else begin
            data_valid <= rd_cmd;  // one cycle per read strobe
        end
    end

endmodule
`default_nettype wire

//--- verilog/countdown_timer.sv
`timescale 1ns/1ps
`default_nettype none

module countdown_timer (
    input  logic             sim_clk,
    input  logic             arst_n,
    input  logic             load,
    input  lvda_pkg::count_t load_value,
    output lvda_pkg::count_t count,
    output logic             timer_done
);

    logic running;
    logic expiring;

    assign running = (count != '0);

    // last step of a countdown, unless a reload takes over
    assign expiring = !load && (count == lvda_pkg::count_t'(1));

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (load) begin
            count <= load_value;  // reload wins over the decrement
        end else if (running) begin
            count <= count - 1'b1;
        end
    end

    // one cycle pulse as the count reaches zero
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            timer_done <= 1'b0;
        end else begin
            timer_done <= expiring;
        end
    end

endmodule
`default_nettype wire

//--- verilog/interrupt_latch.sv
`timescale 1ns/1ps
`default_nettype none

module interrupt_latch (
    input  logic                 sim_clk,
    input  logic                 arst_n,
    input  lvda_pkg::intr_word_t intr,
    input  logic                 clear,
    input  lvda_pkg::intr_word_t clear_mask,
    output lvda_pkg::intr_word_t pending,
    output logic                 intc
);

    lvda_pkg::intr_word_t intr_q;      // filtered lines one clock ago
    lvda_pkg::intr_word_t rise;
    lvda_pkg::intr_word_t clr_bits;
    lvda_pkg::intr_word_t pending_nxt;

    assign rise     = intr & ~intr_q;
    assign clr_bits = clear ? clear_mask : '0;

    // a new edge beats a clear of the same bit
    assign pending_nxt = (pending & ~clr_bits) | rise;

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            intr_q <= '0;
        end else begin
            intr_q <= intr;
        end
    end

    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= '0;
        end else begin
            pending <= pending_nxt;
        end
    end

    // summary request to the processor
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            intc <= 1'b0;
        end else begin
            intc <= |pending_nxt;  // tracks pending in the same cycle
        end
    end

endmodule
`default_nettype wire

//--- verilog/input_filter.sv
`timescale 1ns/1ps
`default_nettype none

module input_filter #(
    parameter type payload_t = logic [0:0]
) (
    input  logic     sim_clk,
    input  logic     arst_n,
    input  payload_t raw,
    output payload_t filtered
);

    payload_t sync_a;
    payload_t sync_b;
    // one agreement counter per bit
    logic [$bits(payload_t)-1:0][lvda_pkg::FILTER_CNT_WIDTH-1:0] agree_cnt;

    // two flop synchronizer on the raw levels
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_a <= '0;
            sync_b <= '0;
        end else begin
            sync_a <= raw;
            sync_b <= sync_a;
        end
    end

    // output bit flips only after FILTER_DEPTH samples disagree with it in a row
    always_ff @(posedge sim_clk or negedge arst_n) begin
        if (!arst_n) begin
            agree_cnt <= '0;
            filtered  <= '0;
        end else begin
            for (int i = 0; i < $bits(payload_t); i++) begin
                if (sync_b[i] == filtered[i]) begin
                    agree_cnt[i] <= '0;  // transient gone, start over
                end else if (agree_cnt[i] == lvda_pkg::FILTER_LAST) begin
                    filtered[i]  <= sync_b[i];
                    agree_cnt[i] <= '0;
                end else begin
                    agree_cnt[i] <= agree_cnt[i] + 1'b1;
                end
            end
        end
    end

endmodule
`default_nettype wire

//--- verilog/lvda_pkg.sv
package lvda_pkg;

    // discrete and interrupt line counts
    localparam int DIN_COUNT  = 24;
    localparam int INTR_COUNT = 7;

    localparam int ADDR_WIDTH  = 9;
    localparam int WORD_WIDTH  = 26;  // buffer register, BRD1..BRD26
    localparam int TIMER_WIDTH = 16;

    // deglitcher needs this many equal samples before it follows the input
    localparam int FILTER_DEPTH     = 3;
    localparam int FILTER_CNT_WIDTH = $clog2(FILTER_DEPTH);
    localparam logic [FILTER_CNT_WIDTH-1:0] FILTER_LAST =
        FILTER_CNT_WIDTH'(FILTER_DEPTH - 1);

    typedef logic [DIN_COUNT-1:0]   din_word_t;
    typedef logic [INTR_COUNT-1:0]  intr_word_t;
    typedef logic [ADDR_WIDTH-1:0]  pio_addr_t;
    typedef logic [WORD_WIDTH-1:0]  word_t;
    typedef logic [TIMER_WIDTH-1:0] count_t;

    // processor port map
    localparam pio_addr_t ADDR_DISCRETE = 9'h008;  // read only
    localparam pio_addr_t ADDR_INTR     = 9'h00c;  // read pending, write clears
    localparam pio_addr_t ADDR_TIMER    = 9'h010;  // read count, write loads

endpackage
